// ==== serial_port.f ====
src/serial_pkg.sv
src/serial_baud_gen.sv
src/serial_arx.sv
src/serial_atx.sv
src/serial_regs.sv
src/serial_top.sv
dv/serial_properties.sv
dv/serial_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the serial port testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert --timescale 1ns/1ns --top-module serial_tb \
    -f serial_port.f --Mdir obj_dir -o serial_tb_sim &&
  ./obj_dir/serial_tb_sim ||
  { echo "serial_tb: build or simulation did not pass"; exit 1; }

// ==== dv/serial_tb.sv ====
// serial port testbench
// table of loopback, bit-banged and bad-stop frames run at two baud
// divisors, checks received data, status flags and gap detection
`timescale 1ns/1ns

module serial_tb import serial_pkg::*; ();

  typedef enum logic [1:0] {SEND_LOOP, SEND_GOOD, SEND_BAD} send_mode_e;

  typedef struct packed {
    logic [7:0] data;
    send_mode_e mode;
    logic       rd_after;  // read data and status after the frame
    logic [2:0] exp;       // frame_err, overrun, rx_full
  } entry_t;

  logic       clk;
  logic       rst;
  logic       rxd;
  logic       txd;
  logic       wr;
  logic       rd;
  reg_addr_e  addr;
  logic [7:0] wdata;
  logic [7:0] rdata;
  logic       loop_sel;   // 1: rxd follows txd
  logic       bang_line;  // bit-banged line level
  int         cur_div;    // divisor now programmed
  int         seed;
  int         div_list [2] = '{2, 5};
  logic [7:0] gap_mask = (8'h01 << ST_RX_IDLE) | (8'h01 << ST_EOP_SEEN);

  entry_t stim [10] = '{
    '{8'h55, SEND_LOOP, 1'b1, 3'b001},
    '{8'hA3, SEND_LOOP, 1'b1, 3'b001},
    '{8'h3C, SEND_GOOD, 1'b1, 3'b001},
    '{8'h81, SEND_BAD,  1'b1, 3'b100},  // low stop bit
    '{8'h0F, SEND_LOOP, 1'b0, 3'b001},  // left unread
    '{8'hE7, SEND_GOOD, 1'b1, 3'b011},  // overruns the one above
    '{8'h00, SEND_LOOP, 1'b1, 3'b001},  // data filled from $random
    '{8'h00, SEND_LOOP, 1'b1, 3'b001},
    '{8'h00, SEND_LOOP, 1'b1, 3'b001},
    '{8'h00, SEND_LOOP, 1'b1, 3'b001}
  };

  assign rxd = loop_sel ? txd : bang_line;

  serial_top dut0 (
    .clk(clk), .rst(rst), .rxd(rxd), .txd(txd), .wr(wr), .rd(rd),
    .addr(addr), .wdata(wdata), .rdata(rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reg_write(input reg_addr_e a, input logic [7:0] d);
    @(negedge clk);
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge clk);
    wr    = 1'b0;
  endtask

  // rdata is registered, taken one cycle after the strobe
  task automatic reg_read(input reg_addr_e a, output logic [7:0] d);
    @(negedge clk);
    rd   = 1'b1;
    addr = a;
    @(negedge clk);
    rd   = 1'b0;
    d    = rdata;
  endtask

  task automatic poll_status(input logic [7:0] mask, output logic [7:0] st);
    int n;
    n = 0;
    reg_read(ADDR_STATUS, st);
    while ((st & mask) != mask) begin
      n++;
      assert (n < 200 * (cur_div + 1)) else begin
        $display("status bits %02h were never set within %0d reads", mask, n);
        end_with_failure();
      end
      reg_read(ADDR_STATUS, st);
    end
  endtask

  task automatic set_divisor(input int d);
    logic [7:0] v;
    logic [7:0] h;
    reg_write(ADDR_DIV_LO, d[7:0]);
    reg_write(ADDR_DIV_HI, d[15:8]);
    cur_div = d;
    reg_read(ADDR_DIV_LO, v);
    reg_read(ADDR_DIV_HI, h);
    assert (v == d[7:0] && h == d[15:8]) else begin
      $display("[FAIL] %0t: divisor %02h%02h, expected %04h", $time, h, v, d[15:0]);
      end_with_failure();
    end
  endtask

  // start, eight data bits lsb first, stop, each OSR ticks long
  task automatic bang_frame(input logic [7:0] b, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      bang_line = bits[i];
      repeat (OSR * (cur_div + 1)) @(negedge clk);
    end
    bang_line = 1'b1;
  endtask

  task automatic run_entry(input entry_t e);
    logic [7:0] st;
    logic [7:0] v;
    loop_sel = (e.mode == SEND_LOOP);
    if (e.mode == SEND_LOOP) begin
      reg_write(ADDR_DATA, e.data);
      reg_read(ADDR_STATUS, st);
      assert (st[ST_TX_BUSY]) else begin
        $display("[FAIL] %0t: tx_busy clear after write of %02h", $time, e.data);
        end_with_failure();
      end
      repeat (4 * OSR * (cur_div + 1)) @(negedge clk);  // about four bits in
      reg_write(ADDR_DATA, ~e.data);                     // dropped, tx busy
      reg_read(ADDR_STATUS, st);
      assert (st[ST_TX_BUSY] && !st[ST_RX_IDLE]) else begin
        $display("[FAIL] %0t: mid-frame status %02h, want busy and not idle", $time, st);
        end_with_failure();
      end
    end else begin
      bang_frame(e.data, e.mode == SEND_GOOD);
    end
    poll_status({5'b00000, e.exp}, st);
    assert (st[2:0] == e.exp) else begin
      $display("[FAIL] %0t: status %02h, expected low bits %03b", $time, st, e.exp);
      end_with_failure();
    end
    if (e.rd_after && e.exp[ST_RX_FULL]) begin
      reg_read(ADDR_DATA, v);
      assert (v == e.data) else begin
        $display("[FAIL] %0t: received %02h, expected %02h", $time, v, e.data);
        end_with_failure();
      end
    end
    if (e.rd_after) begin
      reg_read(ADDR_STATUS, st);  // flags cleared by the reads above
      assert (st[2:0] == 3'b000) else begin
        $display("[FAIL] %0t: status %02h after reads, flags not cleared", $time, st);
        end_with_failure();
      end
    end
    poll_status(gap_mask, st);    // line quiet, idle and eop
    assert (!st[ST_TX_BUSY]) else begin
      $display("[FAIL] %0t: tx_busy still set at gap, status %02h", $time, st);
      end_with_failure();
    end
    if (e.mode == SEND_BAD) begin
      // tail of a low stop bit looks like a new start edge
      reg_read(ADDR_DATA, v);
      reg_read(ADDR_STATUS, st);
    end
  endtask

  initial begin
    int max_div;
    int limit_ns;
    max_div = 0;
    foreach (div_list[p]) if (div_list[p] > max_div) max_div = div_list[p];
    // frames of 12 bit times at the slowest divisor, doubled for margin
    limit_ns = 2 * $size(stim) * $size(div_list) * 12 * OSR * (max_div + 1) * 20 + 20000;
    #(limit_ns);
    $display("run timed out after %0d ns, a frame or status bit never arrived", limit_ns);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [7:0] st;
    int         rnd;
    rst       = 1'b1;
    wr        = 1'b0;
    rd        = 1'b0;
    addr      = ADDR_DATA;
    wdata     = 8'h00;
    loop_sel  = 1'b1;
    bang_line = 1'b1;
    cur_div   = 0;
    seed      = 26;
    for (int i = 6; i < 10; i++) begin
      rnd = $random(seed);
      stim[i].data = rnd[7:0];
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reg_read(ADDR_STATUS, st);
    assert (st == 8'h00) else begin
      $display("[FAIL] %0t: status %02h after reset, expected 00", $time, st);
      end_with_failure();
    end
    poll_status(gap_mask, st);  // first gap after reset
    foreach (div_list[p]) begin
      set_divisor(div_list[p]);
      foreach (stim[i]) run_entry(stim[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== dv/serial_properties.sv ====
// serial port bound checks
// single-cycle strobes, quiet outputs after reset, idle line level
`timescale 1ns/1ns

module serial_properties import serial_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        tick,
  input logic        txd,
  input logic        tx_busy,
  input serial_cfg_t cfg,
  input rx_evt_t     evt
);

  tick_single: assert property (@(posedge clk) disable iff (rst)
    (cfg.div != '0 && tick) |=> !tick) else $error("baud tick high two cycles in a row");

  ready_single: assert property (@(posedge clk) disable iff (rst)
    (cfg.div != '0 && evt.ready) |=> !evt.ready) else $error("rx ready wider than a cycle");

  error_single: assert property (@(posedge clk) disable iff (rst)
    (cfg.div != '0 && evt.error) |=> !evt.error) else $error("rx error wider than a cycle");

  eop_single: assert property (@(posedge clk) disable iff (rst)
    (cfg.div != '0 && evt.eop) |=> !evt.eop) else $error("rx eop wider than a cycle");

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> (!tx_busy && !tick && !evt.ready && !evt.error && !evt.eop))
    else $error("strobe or tx_busy high right after reset");

  idle_high: assert property (@(posedge clk) disable iff (rst)
    !tx_busy |-> txd) else $error("txd low while transmitter idle");

endmodule

bind serial_top serial_properties props0 (
  .clk(clk), .rst(rst), .tick(tick), .txd(txd), .tx_busy(tx_busy), .cfg(cfg), .evt(evt)
);

// ==== src/serial_top.sv ====
// serial port top level
// register block, baud tick generator, receiver and transmitter
// sharing one eight-times-baud tick
`timescale 1ns/1ns

module serial_top import serial_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       txd,
  input  logic       wr,
  input  logic       rd,
  input  reg_addr_e  addr,
  input  logic [7:0] wdata,
  output logic [7:0] rdata
);

  serial_cfg_t cfg;       // divisor to the baud generator
  logic        tick;      // shared baud tick
  rx_evt_t     evt;       // receiver events to the registers
  logic        tx_start;
  logic [7:0]  tx_data;
  logic        tx_busy;

  serial_regs regs0 (
    .clk(clk), .rst(rst), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .rdata(rdata), .cfg(cfg), .evt(evt), .tx_start(tx_start),
    .tx_data(tx_data), .tx_busy(tx_busy)
  );

  serial_baud_gen baud0 (.clk(clk), .rst(rst), .cfg(cfg), .tick(tick));

  serial_arx rx0 (.clk(clk), .rst(rst), .rxd(rxd), .tick(tick), .evt(evt));

  serial_atx tx0 (
    .clk(clk), .rst(rst), .tick(tick), .tx_start(tx_start),
    .tx_data(tx_data), .txd(txd), .tx_busy(tx_busy)
  );

endmodule

// ==== src/serial_regs.sv ====
// serial port register block
// decodes plain read and write strobes, holds the divisor and the
// receive holding register, keeps sticky status flags set by
// receiver events and cleared on read, starts the transmitter
`timescale 1ns/1ns

module serial_regs import serial_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wr,
  input  logic        rd,
  input  reg_addr_e   addr,
  input  logic [7:0]  wdata,
  output logic [7:0]  rdata,
  output serial_cfg_t cfg,
  input  rx_evt_t     evt,
  output logic        tx_start,
  output logic [7:0]  tx_data,
  input  logic        tx_busy
);

  logic [7:0] div_lo;
  logic [7:0] div_hi;
  logic [7:0] rx_data;    // receive holding register
  logic       rx_full;
  logic       overrun;
  logic       frame_err;
  logic       eop_seen;
  logic       rd_data;    // data register read this cycle
  logic       rd_status;  // status register read this cycle
  logic [7:0] status;

  assign rd_data   = rd && addr == ADDR_DATA;
  assign rd_status = rd && addr == ADDR_STATUS;

  // writes to data while busy are dropped here
  assign tx_start = wr && addr == ADDR_DATA && !tx_busy;
  assign tx_data  = wdata;

  assign cfg.div = {div_hi, div_lo};

  always_ff @(posedge clk) begin
    if (rst) begin
      div_lo <= 8'h00;  // tick every clock until programmed
      div_hi <= 8'h00;
    end else if (wr) begin
      if (addr == ADDR_DIV_LO) div_lo <= wdata;
      if (addr == ADDR_DIV_HI) div_hi <= wdata;
    end
  end

  // clear on read first, a same-cycle event wins
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_data   <= 8'h00;
      rx_full   <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
      eop_seen  <= 1'b0;
    end else begin
      if (rd_data) begin
        rx_full <= 1'b0;
        overrun <= 1'b0;
      end
      if (rd_status) begin
        frame_err <= 1'b0;
        eop_seen  <= 1'b0;
      end
      if (evt.ready) begin
        rx_data <= evt.data;            // newest byte replaces older one
        rx_full <= 1'b1;
        if (rx_full && !rd_data) overrun <= 1'b1;
      end
      if (evt.error) frame_err <= 1'b1;
      if (evt.eop)   eop_seen  <= 1'b1;
    end
  end

  always_comb begin
    status               = 8'h00;
    status[ST_RX_FULL]   = rx_full;
    status[ST_OVERRUN]   = overrun;
    status[ST_FRAME_ERR] = frame_err;
    status[ST_TX_BUSY]   = tx_busy;
    status[ST_RX_IDLE]   = evt.idle;
    status[ST_EOP_SEEN]  = eop_seen;
  end

  // registered read data, held until the next read
  always_ff @(posedge clk) begin
    if (rst) rdata <= 8'h00;
    else if (rd) begin
      case (addr)
        ADDR_DATA:   rdata <= rx_data;
        ADDR_STATUS: rdata <= status;
        ADDR_DIV_LO: rdata <= div_lo;
        default:     rdata <= div_hi;
      endcase
    end
  end

endmodule

// ==== src/serial_atx.sv ====
// serial transmitter
// shifts a start bit, eight data bits lsb first and a stop bit
// onto txd, each bit held for OSR baud ticks
`timescale 1ns/1ns

module serial_atx import serial_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       tick,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  output logic       txd,
  output logic       tx_busy
);

  logic [9:0] frame;     // stop, data, start, shifted out from bit 0
  logic [2:0] tick_cnt;  // ticks into the current bit
  logic [3:0] bit_cnt;   // bits already put on the line

  always_ff @(posedge clk) begin
    if (rst) begin
      frame    <= '1;
      tick_cnt <= 3'd0;
      bit_cnt  <= 4'd0;
      txd      <= 1'b1;  // line idles high
      tx_busy  <= 1'b0;
    end else if (tx_start) begin
      frame    <= {1'b1, tx_data, 1'b0};
      tick_cnt <= 3'd0;
      bit_cnt  <= 4'd0;
      tx_busy  <= 1'b1;
    end else if (tx_busy && tick) begin
      tick_cnt <= (tick_cnt == 3'(OSR - 1)) ? 3'd0 : tick_cnt + 3'd1;
      if (tick_cnt == 3'd0) begin  // bit boundary
        if (bit_cnt == 4'd10) begin
          tx_busy <= 1'b0;         // stop bit has run its OSR ticks
        end else begin
          txd     <= frame[0];
          frame   <= {1'b1, frame[9:1]};
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

endmodule

// ==== src/serial_arx.sv ====
// oversampling serial receiver
// synchronizes and filters rxd on baud ticks, walks start, eight
// data bits and stop bit, flags framing errors and reports a gap
// in the character stream as idle plus an end-of-packet pulse
`timescale 1ns/1ns

module serial_arx import serial_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    rxd,
  input  logic    tick,
  output rx_evt_t evt
);

  logic [1:0] sync_inv;   // inverted so idle line reads 0
  logic [1:0] maj_cnt;    // saturating majority counter
  logic       bit_inv;    // filtered, inverted line bit
  rx_state_e  state;
  logic [3:0] spacing;    // sticky bit-spacing counter
  logic       next_bit;   // sample strobe
  logic [7:0] data_q;
  logic       ready_q;
  logic       error_q;
  logic       eop_q;
  logic [4:0] gap_cnt;    // ticks since last character
  logic       stop_smp;   // stop bit sampled this tick

  always_ff @(posedge clk) begin
    if (rst) sync_inv <= 2'b00;
    else if (tick) sync_inv <= {sync_inv[0], ~rxd};
  end

  // filtered bit only flips once the counter hits an extreme
  always_ff @(posedge clk) begin
    if (rst) begin
      maj_cnt <= 2'b00;
      bit_inv <= 1'b0;
    end else if (tick) begin
      if (sync_inv[1] && maj_cnt != 2'b11) maj_cnt <= maj_cnt + 2'd1;
      else if (!sync_inv[1] && maj_cnt != 2'b00) maj_cnt <= maj_cnt - 2'd1;
      if (maj_cnt == 2'b00) bit_inv <= 1'b0;
      else if (maj_cnt == 2'b11) bit_inv <= 1'b1;
    end
  end

  assign next_bit = (spacing == 4'(OSR + 2));  // sample at count 10

  // bit 3 sticks after the first OSR ticks, low bits wrap every bit
  always_ff @(posedge clk) begin
    if (rst || state == RX_IDLE) spacing <= 4'd0;
    else if (tick) spacing <= ({1'b0, spacing[2:0]} + 4'd1) | {spacing[3], 3'b000};
  end

  always_ff @(posedge clk) begin
    if (rst) state <= RX_IDLE;
    else if (tick) begin
      case (state)
        RX_IDLE: if (bit_inv)  state <= RX_BIT0;  // start bit seen
        RX_BIT0: if (next_bit) state <= RX_BIT1;
        RX_BIT1: if (next_bit) state <= RX_BIT2;
        RX_BIT2: if (next_bit) state <= RX_BIT3;
        RX_BIT3: if (next_bit) state <= RX_BIT4;
        RX_BIT4: if (next_bit) state <= RX_BIT5;
        RX_BIT5: if (next_bit) state <= RX_BIT6;
        RX_BIT6: if (next_bit) state <= RX_BIT7;
        RX_BIT7: if (next_bit) state <= RX_STOP;
        RX_STOP: if (next_bit) state <= RX_IDLE;
        default:               state <= RX_IDLE;
      endcase
    end
  end

  assign stop_smp = tick && next_bit && state == RX_STOP;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_q  <= 8'h00;
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      if (tick && next_bit && state[3]) data_q <= {~bit_inv, data_q[7:1]};  // lsb first
      ready_q <= stop_smp && !bit_inv;  // stop bit high on the line
      error_q <= stop_smp && bit_inv;   // stop bit low, framing error
    end
  end

  // gap counter held clear while a character is in progress
  always_ff @(posedge clk) begin
    if (rst) begin
      gap_cnt <= 5'd0;
      eop_q   <= 1'b0;
    end else begin
      if (state != RX_IDLE) gap_cnt <= 5'd0;
      else if (tick && gap_cnt != 5'(GAP_TICKS)) gap_cnt <= gap_cnt + 5'd1;
      eop_q <= tick && gap_cnt == 5'(GAP_TICKS - 1);  // once per gap
    end
  end

  assign evt = '{data: data_q, ready: ready_q, error: error_q, eop: eop_q,
                 idle: (gap_cnt == 5'(GAP_TICKS))};

endmodule

// ==== src/serial_baud_gen.sv ====
// baud tick generator
// down-counter reloaded from the divisor, one-cycle tick at
// eight times the bit rate, restarts when the divisor changes
`timescale 1ns/1ns

module serial_baud_gen import serial_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  serial_cfg_t cfg,
  output logic        tick
);

  logic [DIV_W-1:0] cnt;    // clocks left until next tick
  logic [DIV_W-1:0] div_q;  // divisor the count is based on

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      div_q <= '0;
      tick  <= 1'b0;
    end else if (cfg.div != div_q) begin  // new divisor, restart period
      div_q <= cfg.div;
      cnt   <= cfg.div;
      tick  <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= div_q;                       // reload, period is div+1
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// ==== src/serial_pkg.sv ====
// serial port shared definitions
// localparams, register map, receiver states and the structs
// carried between the register block, baud generator and receiver
package serial_pkg;

  localparam int OSR       = 8;   // ticks per bit
  localparam int DIV_W     = 16;  // baud divisor width
  localparam int GAP_TICKS = 16;  // idle ticks before gap is declared

  // status byte bit positions
  localparam int ST_RX_FULL   = 0;
  localparam int ST_OVERRUN   = 1;
  localparam int ST_FRAME_ERR = 2;
  localparam int ST_TX_BUSY   = 3;
  localparam int ST_RX_IDLE   = 4;
  localparam int ST_EOP_SEEN  = 5;

  typedef enum logic [1:0] {
    ADDR_DATA   = 2'd0,  // rd: rx byte, wr: tx byte
    ADDR_STATUS = 2'd1,  // read only
    ADDR_DIV_LO = 2'd2,
    ADDR_DIV_HI = 2'd3
  } reg_addr_e;

  // data bits carry the high bit, stop bit sits at 1
  typedef enum logic [3:0] {
    RX_IDLE = 4'b0000,
    RX_BIT0 = 4'b1000,
    RX_BIT1 = 4'b1001,
    RX_BIT2 = 4'b1010,
    RX_BIT3 = 4'b1011,
    RX_BIT4 = 4'b1100,
    RX_BIT5 = 4'b1101,
    RX_BIT6 = 4'b1110,
    RX_BIT7 = 4'b1111,
    RX_STOP = 4'b0001
  } rx_state_e;

  typedef struct packed {
    logic [DIV_W-1:0] div;  // tick every div+1 clocks
  } serial_cfg_t;

  typedef struct packed {
    logic [7:0] data;   // last received byte
    logic       ready;  // pulse, good stop bit
    logic       error;  // pulse, bad stop bit
    logic       eop;    // pulse, gap after a burst
    logic       idle;   // level, line quiet
  } rx_evt_t;

endpackage
